/* Bender.yml */
package:
  name: csa_in_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/csa_bridge_pkg.sv
      - logic/word_fifo.sv
      - logic/pack_32_to_40.sv
      - logic/csa_in_bridge.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/csa_in_bridge_tb.sv

/* bench/csa_in_bridge_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_in_bridge_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int IN_W = `CSA_IN_WORD_W;
	localparam int OUT_W = `CSA_OUT_WORD_W;
	localparam int WORDS = `CSA_WORDS_PER_GROUP;
	localparam int SLICES = `CSA_SLICES_PER_GROUP;
	localparam int SEND_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 400;

	localparam int READY_ALWAYS = 0;
	localparam int READY_LOW = 1;
	localparam int READY_RANDOM = 2;

	logic                      axis_s_rclk;
	logic                      rst_n;
	logic                      in_valid;
	logic                      in_ready;
	csa_bridge_pkg::in_word_t  in_data;
	logic                      out_valid;
	logic                      out_ready;
	csa_bridge_pkg::csa_word_t out_data;

	// Reference model state
	csa_bridge_pkg::in_word_t   word_q[$];
	csa_bridge_pkg::csa_word_t  exp_q[$];
	csa_bridge_pkg::group_buf_t model_grp;
	csa_bridge_pkg::csa_word_t  exp_slice;

	int          ready_mode;
	logic        ready_next;
	int          words_accepted;
	int          slices_seen;
	int          remaining;
	bit          saw_stall;
	bit          accepted;
	int unsigned seed_init;

	csa_in_bridge i_dut (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.in_data     (in_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_data    (out_data)
	);

	initial begin
		axis_s_rclk = 1'b0;
		forever #(CLK_PERIOD / 2) axis_s_rclk = ~axis_s_rclk;
	end

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// Holds the word on the bus until the input FIFO takes it
	task automatic send_word(input csa_bridge_pkg::in_word_t w, input bit gaps);
		int waited;
		bit taken;
		waited = 0;
		taken = 1'b0;
		if (gaps && $urandom_range(0, 1) == 0) begin
			in_valid = 1'b0;
			@(posedge axis_s_rclk);
			#DRIVE_DELAY;
		end
		in_valid = 1'b1;
		in_data = w;
		while (!taken) begin
			@(negedge axis_s_rclk);
			taken = in_ready;
			@(posedge axis_s_rclk);
			#DRIVE_DELAY;
			waited++;
			if (!taken && waited >= SEND_TIMEOUT)
				abort_run("Timed out waiting for the bridge to accept an input word");
		end
		in_valid = 1'b0;
	endtask

	task automatic send_group(input bit gaps);
		for (int i = 0; i < WORDS; i++) begin
			send_word($urandom(), gaps);
		end
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			@(posedge axis_s_rclk);
			#DRIVE_DELAY;
			waited++;
			if (waited >= limit)
				abort_run("Timed out waiting for the expected output slices");
		end
	endtask

	// Consumer side ready pattern
	always @(posedge axis_s_rclk) begin
		case (ready_mode)
			READY_LOW:    ready_next = 1'b0;
			READY_RANDOM: ready_next = 1'($urandom_range(0, 1));
			default:      ready_next = 1'b1;
		endcase
		#DRIVE_DELAY;
		out_ready = ready_next;
	end

	// Sampled mid-cycle, values here are the ones seen by the next edge
	always @(negedge axis_s_rclk) begin
		if (rst_n) begin
			if (in_valid && in_ready) begin
				word_q.push_back(in_data);
				words_accepted++;
				if (word_q.size() == WORDS) begin
					model_grp = '0;
					for (int i = 0; i < WORDS; i++)
						model_grp[i*IN_W +: IN_W] = word_q.pop_front();
					for (int j = 0; j < SLICES; j++)
						exp_q.push_back(model_grp[j*OUT_W +: OUT_W]);
				end
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					report_error("slice delivered while no complete group was sent");
				end else begin
					exp_slice = exp_q.pop_front();
					a_slice_match: assert (out_data == exp_slice)
						else report_error($sformatf("slice mismatch got %h expected %h",
							out_data, exp_slice));
					slices_seen++;
				end
			end
		end
	end

	a_out_hold: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	) else report_error("out_data or out_valid changed while the consumer stalled");

	initial begin
		seed_init = $urandom(32'h5ed9);
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		ready_mode = READY_ALWAYS;
		words_accepted = 0;
		slices_seen = 0;
		saw_stall = 1'b0;
		accepted = 1'b0;
		remaining = 0;

		for (int c = 0; c < 5; c++) begin
			@(posedge axis_s_rclk);
			#DRIVE_DELAY;
			a_reset_idle: assert (out_valid === 1'b0)
				else report_error("out_valid high during reset");
		end
		rst_n = 1'b1;
		@(posedge axis_s_rclk);
		#DRIVE_DELAY;
		a_after_reset_idle: assert (out_valid === 1'b0)
			else report_error("out_valid high on the first edge after reset");
		a_after_reset_ready: assert (in_ready === 1'b1)
			else report_error("in_ready low after reset release");

		// Straight conversion with no stalls
		for (int g = 0; g < 40; g++)
			send_group(1'b0);
		wait_drain(DRAIN_TIMEOUT);

		// Four words only, nothing may come out yet
		for (int i = 0; i < WORDS - 1; i++)
			send_word($urandom(), 1'b0);
		for (int c = 0; c < 20; c++) begin
			@(negedge axis_s_rclk);
			a_partial_held: assert (out_valid === 1'b0)
				else report_error("out_valid raised before a group was complete");
		end
		@(posedge axis_s_rclk);
		#DRIVE_DELAY;
		send_word($urandom(), 1'b0);
		wait_drain(30);

		// Consumer stalled while input keeps coming
		ready_mode = READY_LOW;
		in_valid = 1'b1;
		in_data = $urandom();
		for (int c = 0; c < 60; c++) begin
			@(negedge axis_s_rclk);
			accepted = in_ready;
			if (!in_ready)
				saw_stall = 1'b1;
			@(posedge axis_s_rclk);
			#DRIVE_DELAY;
			if (accepted)
				in_data = $urandom();
		end
		a_backpressure: assert (saw_stall)
			else report_error("in_ready never dropped while out_ready was held low");
		ready_mode = READY_ALWAYS;
		// A word still waiting on the bus stays offered until taken
		if (!accepted)
			send_word(in_data, 1'b0);
		else
			in_valid = 1'b0;
		remaining = (WORDS - word_q.size()) % WORDS;
		for (int i = 0; i < remaining; i++)
			send_word($urandom(), 1'b0);
		wait_drain(DRAIN_TIMEOUT);

		// Random gaps on both sides
		ready_mode = READY_RANDOM;
		for (int g = 0; g < 30; g++)
			send_group(1'b1);
		ready_mode = READY_ALWAYS;
		wait_drain(DRAIN_TIMEOUT);

		repeat (10) @(posedge axis_s_rclk);
		#DRIVE_DELAY;
		if (exp_q.size() == 0 && word_q.size() == 0 &&
			out_valid === 1'b0 && in_ready === 1'b1 &&
			slices_seen == (words_accepted / WORDS) * SLICES) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Bridge not idle or slice count does not match the words sent");
			$display("RESULT: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* include/csa_bridge_params.svh */
`ifndef CSA_BRIDGE_PARAMS_SVH
`define CSA_BRIDGE_PARAMS_SVH

// Input bus word, as delivered by the stream source
`define CSA_IN_WORD_W 32

// One operand slice for the carry-save adder input
`define CSA_OUT_WORD_W 40

// Five input words fill exactly four output slices (160 bits)
`define CSA_WORDS_PER_GROUP 5
`define CSA_SLICES_PER_GROUP 4

// Input side buffering
`define CSA_IN_FIFO_DEPTH 8

// Output side buffering, absorbs adder stalls
`define CSA_OUT_FIFO_DEPTH 8

`endif

/* logic/csa_bridge_pkg.sv */
`default_nettype none

`include "csa_bridge_params.svh"

package csa_bridge_pkg;

	// Word as it arrives from the input bus
	typedef logic [`CSA_IN_WORD_W-1:0] in_word_t;

	// Slice handed to the adder datapath
	typedef logic [`CSA_OUT_WORD_W-1:0] csa_word_t;

	// Whole group, word 0 in the lowest bits
	typedef logic [`CSA_WORDS_PER_GROUP*`CSA_IN_WORD_W-1:0] group_buf_t;

endpackage

`default_nettype wire

/* logic/csa_in_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module csa_in_bridge (
	input  logic                      axis_s_rclk,
	input  logic                      rst_n,

	input  logic                      in_valid,
	output logic                      in_ready,
	input  csa_bridge_pkg::in_word_t  in_data,

	output logic                      out_valid,
	input  logic                      out_ready,
	output csa_bridge_pkg::csa_word_t out_data
);

	// Input FIFO to packer
	logic                      word_valid;
	logic                      word_ready;
	csa_bridge_pkg::in_word_t  word_data;

	// Packer to output FIFO
	logic                      slice_valid;
	logic                      slice_ready;
	csa_bridge_pkg::csa_word_t slice_data;

	word_fifo #(
		.payload_t (csa_bridge_pkg::in_word_t),
		.DEPTH     (`CSA_IN_FIFO_DEPTH)
	) i_in_fifo (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.push_valid  (in_valid),
		.push_ready  (in_ready),
		.push_data   (in_data),
		.pop_valid   (word_valid),
		.pop_ready   (word_ready),
		.pop_data    (word_data)
	);

	pack_32_to_40 i_pack (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.word_valid  (word_valid),
		.word_ready  (word_ready),
		.word_data   (word_data),
		.slice_valid (slice_valid),
		.slice_ready (slice_ready),
		.slice_data  (slice_data)
	);

	word_fifo #(
		.payload_t (csa_bridge_pkg::csa_word_t),
		.DEPTH     (`CSA_OUT_FIFO_DEPTH)
	) i_out_fifo (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.push_valid  (slice_valid),
		.push_ready  (slice_ready),
		.push_data   (slice_data),
		.pop_valid   (out_valid),
		.pop_ready   (out_ready),
		.pop_data    (out_data)
	);

endmodule

`default_nettype wire

/* logic/pack_32_to_40.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csa_bridge_params.svh"

module pack_32_to_40 (
	input  logic                      axis_s_rclk,
	input  logic                      rst_n,

	input  logic                      word_valid,
	output logic                      word_ready,
	input  csa_bridge_pkg::in_word_t  word_data,

	output logic                      slice_valid,
	input  logic                      slice_ready,
	output csa_bridge_pkg::csa_word_t slice_data
);

	localparam int IN_W  = $bits(csa_bridge_pkg::in_word_t);
	localparam int OUT_W = $bits(csa_bridge_pkg::csa_word_t);
	localparam int WIDX_W = $clog2(`CSA_WORDS_PER_GROUP);
	localparam int SIDX_W = $clog2(`CSA_SLICES_PER_GROUP);

	// Gather side
	csa_bridge_pkg::group_buf_t gather_buf;
	logic [WIDX_W-1:0]          word_idx;
	logic                       group_full;

	// Emit side
	csa_bridge_pkg::group_buf_t emit_buf;
	logic [SIDX_W-1:0]          slice_idx;
	logic                       emit_busy;

	logic word_fire;
	logic slice_fire;
	logic handoff;
	logic last_word;
	logic last_slice;

	// Stall input only when two groups are already in flight
	assign word_ready = !(group_full && emit_busy);
	assign word_fire  = word_valid && word_ready;
	assign last_word  = (word_idx == WIDX_W'(`CSA_WORDS_PER_GROUP - 1));

	assign handoff = group_full && !emit_busy;

	assign slice_valid = emit_busy;
	assign slice_data  = emit_buf[slice_idx*OUT_W +: OUT_W];
	assign slice_fire  = slice_valid && slice_ready;
	assign last_slice  = (slice_idx == SIDX_W'(`CSA_SLICES_PER_GROUP - 1));

	// Word n lands at bit n*32.
	// The old contents are still copied out on a handoff edge,
	// so word 0 of the next group can be written at the same time
	always_ff @(posedge axis_s_rclk) begin
		if (word_fire) begin
			gather_buf[word_idx*IN_W +: IN_W] <= word_data;
		end
	end

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			word_idx   <= '0;
			group_full <= 1'b0;
		end else begin
			if (handoff) begin
				group_full <= 1'b0;
			end
			if (word_fire) begin
				if (last_word) begin
					word_idx   <= '0;
					group_full <= 1'b1;
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// Emit register payload
	always_ff @(posedge axis_s_rclk) begin
		if (handoff) begin
			emit_buf <= gather_buf;
		end
	end

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			emit_busy <= 1'b0;
			slice_idx <= '0;
		end else begin
			if (handoff) begin
				emit_busy <= 1'b1;
				slice_idx <= '0;
			end else if (slice_fire) begin
				if (last_slice) begin
					emit_busy <= 1'b0;
					slice_idx <= '0;
				end else begin
					slice_idx <= slice_idx + 1'b1;
				end
			end
		end
	end

	// Stalled slice must be held until the output FIFO takes it
	a_slice_stable: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		slice_valid && !slice_ready |=> slice_valid && $stable(slice_data)
	);

	a_word_idx_range: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		word_idx < WIDX_W'(`CSA_WORDS_PER_GROUP)
	);

endmodule

`default_nettype wire

/* logic/word_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module word_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 8
) (
	input  logic     axis_s_rclk,
	input  logic     rst_n,

	input  logic     push_valid,
	output logic     push_ready,
	input  payload_t push_data,

	output logic     pop_valid,
	input  logic     pop_ready,
	output payload_t pop_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic push_fire;
	logic pop_fire;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid  = (count != '0);
	assign pop_data   = mem[rd_ptr];

	assign push_fire = push_valid && push_ready;
	assign pop_fire  = pop_valid && pop_ready;

	// Storage
	always_ff @(posedge axis_s_rclk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire) begin
				if (wr_ptr == PTR_W'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_fire) begin
				if (rd_ptr == PTR_W'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (push_fire && !pop_fire)
				count <= count + 1'b1;
			else if (pop_fire && !push_fire)
				count <= count - 1'b1;
		end
	end

	a_count_in_range: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		count <= CNT_W'(DEPTH)
	);

	// Head entry must not move under a stalled reader
	a_pop_stable: assert property (
		@(posedge axis_s_rclk) disable iff (!rst_n)
		pop_valid && !pop_ready |=> pop_valid && $stable(pop_data)
	);

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
logic/csa_bridge_pkg.sv
logic/word_fifo.sv
logic/pack_32_to_40.sv
logic/csa_in_bridge.sv
bench/csa_in_bridge_tb.sv
